//--- design/port_capture.sv
`default_nettype none

module port_capture (
   input  wire                           clkram,
   input  wire                           new_scr,
   input  wire                           capture_slot_ok,   // from mux, slot and init ok
   input  wire  sdram_pkg::client_req_t  req,
   output logic                          ready,
   output sdram_pkg::client_req_t        held,
   input  wire                           lo_strobe,         // bank 0 data on dq now
   input  wire                           hi_strobe,         // bank 1 data, access done
   input  wire  [sdram_pkg::HALF_W-1:0]  dq_in,
   output sdram_pkg::client_rsp_t        rsp
);

   sdram_pkg::client_req_t        req_q;       // request payload, valid field unused
   logic [sdram_pkg::DATA_W-1:0]  rdata;
   logic                          busy;        // accepted, response not yet sent
   logic                          rsp_valid;
   logic                          accept;

   assign ready  = capture_slot_ok & ~busy;
   assign accept = ready & req.valid;

   // ----------------------------------------------------------
   // control
   // ----------------------------------------------------------
   always_ff @(posedge clkram or posedge new_scr) begin
      if (new_scr) begin
         busy      <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         if (accept) busy <= 1'b1;
         else if (hi_strobe) busy <= 1'b0;
         rsp_valid <= hi_strobe & busy;   // write gets the same pulse as an ack
      end
   end

   // payload and read assembly
   always_ff @(posedge clkram) begin
      if (accept) req_q <= req;
      if (lo_strobe) rdata[sdram_pkg::HALF_W-1:0] <= dq_in;
      if (hi_strobe) rdata[sdram_pkg::DATA_W-1:sdram_pkg::HALF_W] <= dq_in;
   end

   always_comb begin
      held       = req_q;
      held.valid = busy;   // mux only looks at a pending request
   end

   assign rsp = '{valid: rsp_valid, rdata: rdata};

   // one request in flight per port
   a_no_second_accept: assert property (@(posedge clkram) disable iff (new_scr)
      accept |=> (!accept until rsp_valid));

endmodule

`default_nettype wire

//--- design/sdram_cmd_mux.sv
`default_nettype none

module sdram_cmd_mux (
   input  wire                           clkram,
   input  wire                           new_scr,
   input  wire  [sdram_pkg::SLOT_W-1:0]  slot,
   input  wire                           refresh_half,
   input  wire                           refresh_next,
   input  wire                           init_done,
   input  wire  sdram_pkg::sdram_bus_t   init_bus,
   input  wire  sdram_pkg::client_req_t  ppu_held,
   input  wire  sdram_pkg::client_req_t  cpu_held,
   output logic                          ppu_ok,
   output logic                          cpu_ok,
   output logic                          ppu_lo,
   output logic                          ppu_hi,
   output logic                          cpu_lo,
   output logic                          cpu_hi,
   output sdram_pkg::sdram_bus_t         bus
);

   // decision slot to sampling edge: pin register plus cas latency
   localparam int STB_D = sdram_pkg::CAS_LAT + 1;

   typedef struct packed {
      logic fire;   // column command issued
      logic cpu;    // owning port
   } stb_t;

   sdram_pkg::client_req_t        cur;      // request of the half's owner
   sdram_pkg::sdram_bus_t         nxt;
   logic [sdram_pkg::ROW_W-1:0]   row;
   logic [sdram_pkg::ROW_W-1:0]   col_ap;   // column with a10 auto-precharge
   logic [2:0]                    h;        // slot inside the half
   logic                          cpu_half;
   logic                          serve;
   stb_t                          lo_new;
   stb_t                          hi_new;
   stb_t [STB_D-1:0]              lo_sr;
   stb_t [STB_D-1:0]              hi_sr;

   assign cpu_half = (slot >= sdram_pkg::SLOT_W'(sdram_pkg::CPU_SLOT_BASE));
   assign h        = slot[2:0];
   assign cur      = cpu_half ? cpu_held : ppu_held;
   assign serve    = init_done & ~refresh_half & cur.valid;
   assign row      = cur.addr[sdram_pkg::ADDR_W-1:sdram_pkg::COL_W];
   assign col_ap   = {1'b1, {(sdram_pkg::ROW_W-1-sdram_pkg::COL_W){1'b0}},
                      cur.addr[sdram_pkg::COL_W-1:0]};

   // capture permits, the slot before each half begins
   assign ppu_ok = init_done & (slot == '1) & ~refresh_next;
   assign cpu_ok = init_done & (slot == sdram_pkg::SLOT_W'(sdram_pkg::CPU_SLOT_BASE - 1));

   // ----------------------------------------------------------
   // per slot command table
   // ----------------------------------------------------------
   always_comb begin
      nxt = sdram_pkg::BUS_IDLE;
      if (!init_done) begin
         nxt = init_bus;
      end else if (refresh_half) begin
         if (h == 3'd7) nxt.cmd = sdram_pkg::CMD_AUTO_REFRESH;
      end else if (cur.valid) begin
         case (h)
            3'd0, 3'd3: begin   // open row, bank 0 then bank 1
               nxt.cmd = sdram_pkg::CMD_ACTIVE;
               nxt.ba  = {1'b0, h[0]};
               nxt.a   = row;
            end
            3'd2, 3'd5: begin   // h[0] picks bank and half
               nxt.ba = {1'b0, h[0]};
               nxt.a  = col_ap;
               if (cur.write) begin
                  nxt.cmd    = sdram_pkg::CMD_WRITE;
                  nxt.dq_oe  = 1'b1;
                  nxt.dq_out = h[0] ? cur.wdata[sdram_pkg::DATA_W-1:sdram_pkg::HALF_W]
                                    : cur.wdata[sdram_pkg::HALF_W-1:0];
                  nxt.dqml   = ~(h[0] ? cur.be[2] : cur.be[0]);   // dqm masks, be enables
                  nxt.dqmh   = ~(h[0] ? cur.be[3] : cur.be[1]);
               end else begin
                  nxt.cmd  = sdram_pkg::CMD_READ;
                  nxt.dqml = 1'b0;
                  nxt.dqmh = 1'b0;
               end
            end
            default: ;   // inhibit
         endcase
      end
   end

   // low strobe only matters for reads, high one also closes writes
   assign lo_new = '{fire: serve & (h == 3'd2) & ~cur.write, cpu: cpu_half};
   assign hi_new = '{fire: serve & (h == 3'd5), cpu: cpu_half};

   always_ff @(posedge clkram or posedge new_scr) begin
      if (new_scr) begin
         bus   <= sdram_pkg::BUS_IDLE;
         lo_sr <= '0;
         hi_sr <= '0;
      end else begin
         bus   <= nxt;
         lo_sr <= {lo_sr[STB_D-2:0], lo_new};
         hi_sr <= {hi_sr[STB_D-2:0], hi_new};   // lands in the other half
      end
   end

   assign ppu_lo = lo_sr[STB_D-1].fire & ~lo_sr[STB_D-1].cpu;
   assign cpu_lo = lo_sr[STB_D-1].fire &  lo_sr[STB_D-1].cpu;
   assign ppu_hi = hi_sr[STB_D-1].fire & ~hi_sr[STB_D-1].cpu;
   assign cpu_hi = hi_sr[STB_D-1].fire &  hi_sr[STB_D-1].cpu;

   a_oe_only_write: assert property (@(posedge clkram) disable iff (new_scr)
      bus.dq_oe |-> bus.cmd == sdram_pkg::CMD_WRITE);

   // a strobe always finds its port still waiting
   a_strobe_pending: assert property (@(posedge clkram) disable iff (new_scr)
      (ppu_hi |-> ppu_held.valid) and (cpu_hi |-> cpu_held.valid));

endmodule

`default_nettype wire

//--- design/sdram_ctrl_top.sv
`default_nettype none

module sdram_ctrl_top #(
   parameter int INIT_CYCLES      = 8,
   parameter int REFRESH_INTERVAL = 4
) (
   input  wire                              clkram,
   input  wire                              new_scr,
   input  wire  sdram_pkg::client_req_t     ppu_req,
   output logic                             ppu_ready,
   output sdram_pkg::client_rsp_t           ppu_rsp,
   input  wire  sdram_pkg::client_req_t     cpu_req,
   output logic                             cpu_ready,
   output sdram_pkg::client_rsp_t           cpu_rsp,
   // chip pins
   output logic [sdram_pkg::ROW_W-1:0]      sdram_a,
   output logic [1:0]                       sdram_ba,
   inout  wire  [sdram_pkg::HALF_W-1:0]     sdram_dq,
   output logic                             sdram_ncs,
   output logic                             sdram_nras,
   output logic                             sdram_ncas,
   output logic                             sdram_nwe,
   output logic                             sdram_dqml,
   output logic                             sdram_dqmh
);

   logic [sdram_pkg::SLOT_W-1:0]  slot;
   logic                          refresh_half;
   logic                          refresh_next;
   logic                          init_done;
   logic                          ppu_ok, cpu_ok;
   logic                          ppu_lo, ppu_hi, cpu_lo, cpu_hi;
   logic [sdram_pkg::HALF_W-1:0]  dq_in;
   sdram_pkg::sdram_bus_t         init_bus;
   sdram_pkg::sdram_bus_t         bus;
   sdram_pkg::client_req_t        ppu_held, cpu_held;

   slot_sequencer #(.REFRESH_INTERVAL(REFRESH_INTERVAL)) u_seq (
      .clkram, .new_scr, .slot, .refresh_half, .refresh_next);

   sdram_init_seq #(.INIT_CYCLES(INIT_CYCLES)) u_init (
      .clkram, .new_scr, .slot, .init_bus, .init_done);

   port_capture ppu_port (
      .clkram, .new_scr, .capture_slot_ok(ppu_ok), .req(ppu_req), .ready(ppu_ready),
      .held(ppu_held), .lo_strobe(ppu_lo), .hi_strobe(ppu_hi), .dq_in, .rsp(ppu_rsp));

   port_capture cpu_port (
      .clkram, .new_scr, .capture_slot_ok(cpu_ok), .req(cpu_req), .ready(cpu_ready),
      .held(cpu_held), .lo_strobe(cpu_lo), .hi_strobe(cpu_hi), .dq_in, .rsp(cpu_rsp));

   sdram_cmd_mux u_mux (
      .clkram, .new_scr, .slot, .refresh_half, .refresh_next, .init_done, .init_bus,
      .ppu_held, .cpu_held, .ppu_ok, .cpu_ok, .ppu_lo, .ppu_hi, .cpu_lo, .cpu_hi, .bus);

   // ----------------------------------------------------------
   // registered bus out to the pins
   // ----------------------------------------------------------
   assign {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = bus.cmd;
   assign sdram_a    = bus.a;
   assign sdram_ba   = bus.ba;
   assign sdram_dqml = bus.dqml;
   assign sdram_dqmh = bus.dqmh;
   assign sdram_dq   = bus.dq_oe ? bus.dq_out : 'z;   // released except on writes
   assign dq_in      = sdram_dq;

endmodule

`default_nettype wire

//--- design/sdram_init_seq.sv
`default_nettype none

module sdram_init_seq #(
   parameter int INIT_CYCLES = 8    // 16-slot cycles of power-up wait, at least 3
) (
   input  wire                          clkram,
   input  wire                          new_scr,
   input  wire  [sdram_pkg::SLOT_W-1:0] slot,
   output sdram_pkg::sdram_bus_t        init_bus,
   output logic                         init_done
);

   localparam int CNT_W = $clog2(INIT_CYCLES + 1);

   logic [CNT_W-1:0] cnt;   // cycles left before normal operation

   // ----------------------------------------------------------
   // countdown, one step per full cycle
   // ----------------------------------------------------------
   always_ff @(posedge clkram or posedge new_scr) begin
      if (new_scr) begin
         cnt <= CNT_W'(INIT_CYCLES);
      end else if (slot == '1 && cnt != '0) begin
         cnt <= cnt - 1'b1;
      end
   end

   assign init_done = (cnt == '0);   // rises at the edge closing the last cycle

   // precharge-all two cycles before load mode, tRP is easily covered
   always_comb begin
      init_bus = sdram_pkg::BUS_IDLE;
      if (slot == '0) begin
         if (cnt == CNT_W'(3)) begin
            init_bus.cmd   = sdram_pkg::CMD_PRECHARGE;
            init_bus.a[10] = 1'b1;                       // all banks
         end else if (cnt == CNT_W'(1)) begin
            init_bus.cmd = sdram_pkg::CMD_LOAD_MODE;
            init_bus.a   = sdram_pkg::MODE_WORD;
         end
      end
   end

   // the power-up path must never open a row or touch data
   a_init_no_access: assert property (@(posedge clkram) disable iff (new_scr)
      !(init_bus.cmd inside {sdram_pkg::CMD_ACTIVE, sdram_pkg::CMD_READ,
                             sdram_pkg::CMD_WRITE}));

endmodule

`default_nettype wire

//--- design/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

   // ----------------------------------------------------------
   // sizes
   // ----------------------------------------------------------
   localparam int ROW_W  = 11;              // row, also chip address bus width
   localparam int COL_W  = 8;               // column inside a row
   localparam int ADDR_W = ROW_W + COL_W;   // client word address
   localparam int DATA_W = 32;              // client word
   localparam int HALF_W = 16;              // chip dq width
   localparam int BE_W   = 4;               // one enable per client byte

   // slot counter, ppu owns 0..7 and cpu owns 8..15
   localparam int SLOT_W        = 4;
   localparam int CPU_SLOT_BASE = 8;

   // ----------------------------------------------------------
   // chip commands {ncs, nras, ncas, nwe}
   // ----------------------------------------------------------
   typedef enum logic [3:0] {
      CMD_INHIBIT      = 4'b1111,
      CMD_NOP          = 4'b0111,
      CMD_ACTIVE       = 4'b0011,
      CMD_READ         = 4'b0101,
      CMD_WRITE        = 4'b0100,
      CMD_BURST_TERM   = 4'b0110,
      CMD_PRECHARGE    = 4'b0010,
      CMD_AUTO_REFRESH = 4'b0001,
      CMD_LOAD_MODE    = 4'b0000
   } sdram_cmd_e;

   localparam int CAS_LAT = 2;

   // single word bursts, sequential, cl2, std op, single writes
   localparam logic [ROW_W-1:0] MODE_WORD = {1'b0, 1'b1, 2'b00, 3'd2, 1'b0, 3'b000};

   // ----------------------------------------------------------
   // packed bundles
   // ----------------------------------------------------------
   typedef struct packed {
      logic              valid;
      logic              write;
      logic [ADDR_W-1:0] addr;    // {row, col}
      logic [DATA_W-1:0] wdata;
      logic [BE_W-1:0]   be;      // high = byte is written
   } client_req_t;

   typedef struct packed {
      logic              valid;   // one cycle pulse
      logic [DATA_W-1:0] rdata;
   } client_rsp_t;

   typedef struct packed {
      sdram_cmd_e        cmd;
      logic [1:0]        ba;
      logic [ROW_W-1:0]  a;
      logic              dqml;
      logic              dqmh;
      logic [HALF_W-1:0] dq_out;
      logic              dq_oe;
   } sdram_bus_t;

   // quiet pin state: inhibit, masks up, dq released
   localparam sdram_bus_t BUS_IDLE = '{cmd: CMD_INHIBIT, ba: '0, a: '0, dqml: 1'b1,
                                       dqmh: 1'b1, dq_out: '0, dq_oe: 1'b0};

endpackage

`default_nettype wire

//--- design/slot_sequencer.sv
`default_nettype none

module slot_sequencer #(
   parameter int REFRESH_INTERVAL = 4   // cycles from one refresh to the next
) (
   input  wire                          clkram,
   input  wire                          new_scr,
   output logic [sdram_pkg::SLOT_W-1:0] slot,
   output logic                         refresh_half,   // first half is a refresh
   output logic                         refresh_next    // next cycle starts with refresh
);

   localparam int CYC_W = (REFRESH_INTERVAL > 1) ? $clog2(REFRESH_INTERVAL) : 1;

   logic [CYC_W-1:0] cyc;   // cycle index modulo interval

   // look ahead for the ppu capture slot at the end of the cycle
   assign refresh_next = (cyc == CYC_W'(REFRESH_INTERVAL - 1));

   always_ff @(posedge clkram or posedge new_scr) begin
      if (new_scr) begin
         slot         <= '0;
         cyc          <= '0;
         refresh_half <= 1'b1;   // count starts at zero
      end else begin
         slot <= slot + 1'b1;   // wraps 15 -> 0
         if (slot == '1) begin
            if (cyc == CYC_W'(REFRESH_INTERVAL - 1)) cyc <= '0;
            else cyc <= cyc + 1'b1;
            refresh_half <= refresh_next;   // next cycle opens with refresh
         end else if (slot == sdram_pkg::SLOT_W'(sdram_pkg::CPU_SLOT_BASE - 1)) begin
            refresh_half <= 1'b0;           // cpu half never refreshes
         end
      end
   end

   // refresh only ever steals from the ppu half
   a_refresh_first_half: assert property (@(posedge clkram) disable iff (new_scr)
      refresh_half |-> slot < sdram_pkg::SLOT_W'(sdram_pkg::CPU_SLOT_BASE));

endmodule

`default_nettype wire

//--- project.f
design/sdram_pkg.sv
design/slot_sequencer.sv
design/sdram_init_seq.sv
design/port_capture.sv
design/sdram_cmd_mux.sv
design/sdram_ctrl_top.sv
testbench/sdram_chip_model.sv
testbench/tb_sdram_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# build and run the sdram controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_sdram_ctrl -o sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
   exit 0
fi
exit 1

//--- testbench/sdram_chip_model.sv
`default_nettype none

module sdram_chip_model (
   input  wire                           clkram,
   input  wire   [sdram_pkg::ROW_W-1:0]  a,
   input  wire   [1:0]                   ba,
   inout  wire   [sdram_pkg::HALF_W-1:0] dq,
   input  wire                           ncs,
   input  wire                           nras,
   input  wire                           ncas,
   input  wire                           nwe,
   input  wire                           dqml,
   input  wire                           dqmh,
   output int                            refresh_cnt,
   output int                            early_active,         // rows opened too soon
   output logic                          precharge_all_seen,
   output logic                          mode_seen,            // mode load after precharge-all
   output logic  [sdram_pkg::ROW_W-1:0]  mode_val
);

   localparam int CAS_LAT = sdram_pkg::CAS_LAT;
   localparam int KEY_W   = 2 + sdram_pkg::ROW_W + sdram_pkg::COL_W;

   sdram_pkg::sdram_cmd_e         cmd;
   logic [sdram_pkg::HALF_W-1:0]  mem [logic [KEY_W-1:0]];   // sparse, {bank, row, col}
   logic [sdram_pkg::ROW_W-1:0]   open_row [0:3];
   logic [KEY_W-1:0]              key;
   logic [CAS_LAT-1:0]            rd_v = '0;                 // read pipe, oldest at top
   logic [sdram_pkg::HALF_W-1:0]  rd_d [CAS_LAT];

   assign cmd = sdram_pkg::sdram_cmd_e'({ncs, nras, ncas, nwe});
   assign key = {ba, open_row[ba], a[sdram_pkg::COL_W-1:0]};
   assign dq  = rd_v[CAS_LAT-1] ? rd_d[CAS_LAT-1] : 'z;   // one cycle of read data

   initial begin
      refresh_cnt        = 0;
      early_active       = 0;
      precharge_all_seen = 1'b0;
      mode_seen          = 1'b0;
      mode_val           = '0;
   end

   // ----------------------------------------------------------
   // command decode on every rising edge
   // ----------------------------------------------------------
   always @(posedge clkram) begin : decode
      logic [sdram_pkg::HALF_W-1:0] word;
      logic                         rd_now;
      rd_now = 1'b0;
      word   = mem.exists(key) ? mem[key] : '0;
      case (cmd)
         sdram_pkg::CMD_ACTIVE: begin
            open_row[ba] = a;
            if (!(precharge_all_seen && mode_seen)) early_active++;
         end
         sdram_pkg::CMD_READ: rd_now = 1'b1;   // dqm ignored, single word
         sdram_pkg::CMD_WRITE: begin
            if (!dqml) word[7:0] = dq[7:0];      // dqm high masks the byte
            if (!dqmh) word[15:8] = dq[15:8];
            mem[key] = word;
         end
         sdram_pkg::CMD_AUTO_REFRESH: refresh_cnt++;
         sdram_pkg::CMD_PRECHARGE: if (a[10]) precharge_all_seen = 1'b1;
         sdram_pkg::CMD_LOAD_MODE: begin
            mode_seen = precharge_all_seen;
            mode_val  = a;
         end
         default: ;
      endcase
      rd_v    <= {rd_v[CAS_LAT-2:0], rd_now};
      rd_d[0] <= word;
      for (int i = 1; i < CAS_LAT; i++) rd_d[i] <= rd_d[i-1];
   end

endmodule

`default_nettype wire

//--- testbench/tb_sdram_ctrl.sv
`default_nettype none

module tb_sdram_ctrl;

   localparam int INIT_CYCLES      = 8;
   localparam int REFRESH_INTERVAL = 4;
   localparam int POOL             = 16;   // small so ports keep hitting the same words
   // a10 0, single-access writes, std op, cl2, sequential, burst 1
   localparam logic [10:0] MODE_EXP = {1'b0, 1'b1, 2'b00, 3'b010, 1'b0, 3'b000};

   logic                    clkram = 1'b0;
   logic                    new_scr;
   sdram_pkg::client_req_t  ppu_req, cpu_req;
   logic                    ppu_ready, cpu_ready;
   sdram_pkg::client_rsp_t  ppu_rsp, cpu_rsp;
   wire [10:0]              sdram_a;
   wire [1:0]               sdram_ba;
   wire [15:0]              sdram_dq;
   wire                     sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe;
   wire                     sdram_dqml, sdram_dqmh;
   int                      refresh_cnt, early_active;
   logic                    pre_all_seen, mode_seen;
   logic [10:0]             mode_val;

   int          seed = 11040;
   int          errors = 0;
   int          cycles = 0;
   int          acc_cnt [2] = '{0, 0};   // index 0 ppu, 1 cpu
   int          hs_cnt [2] = '{0, 0};
   int          rsp_cnt [2] = '{0, 0};
   logic [31:0] ref_mem [logic [18:0]];  // expected client words
   logic [18:0] pool [POOL];

   always #5 clkram = ~clkram;
   always @(posedge clkram) cycles++;

   sdram_ctrl_top #(.INIT_CYCLES(INIT_CYCLES), .REFRESH_INTERVAL(REFRESH_INTERVAL)) dut (.*);

   sdram_chip_model u_chip (
      .clkram, .a(sdram_a), .ba(sdram_ba), .dq(sdram_dq), .ncs(sdram_ncs), .nras(sdram_nras),
      .ncas(sdram_ncas), .nwe(sdram_nwe), .dqml(sdram_dqml), .dqmh(sdram_dqmh),
      .refresh_cnt, .early_active, .precharge_all_seen(pre_all_seen), .mode_seen, .mode_val);

   // ----------------------------------------------------------
   // handshake and response monitor, mid-cycle
   // ----------------------------------------------------------
   always @(negedge clkram) begin
      if (!new_scr) begin
         if ((ppu_ready || cpu_ready) && !mode_seen) begin
            errors++;
            $display("ready raised before precharge-all and load mode were seen");
         end
         if (ppu_req.valid && ppu_ready) hs_cnt[0]++;
         if (cpu_req.valid && cpu_ready) hs_cnt[1]++;
         if (ppu_rsp.valid) rsp_cnt[0]++;   // any pulse, wanted or not
         if (cpu_rsp.valid) rsp_cnt[1]++;
      end
   end

   // one access, entered 1 unit after a rising edge, leaves valid up
   task automatic access(input bit is_cpu, input bit wr, input logic [18:0] addr,
                         input logic [31:0] wd, input logic [3:0] be, input string name);
      sdram_pkg::client_req_t r;
      sdram_pkg::client_rsp_t rsp;
      logic [31:0]            expected;
      logic                   rdy;
      int                     n;
      r   = '{valid: 1'b1, write: wr, addr: addr, wdata: wd, be: be};
      rsp = '0;
      rdy = 1'b0;
      n   = 0;
      if (is_cpu) cpu_req = r;
      else ppu_req = r;
      while (!rdy && n < 100) begin
         @(negedge clkram);
         rdy = is_cpu ? cpu_ready : ppu_ready;
         n++;
      end
      if (!rdy) begin
         errors++;
         $display("%s: request at %h never accepted", name, addr);
         return;
      end
      @(posedge clkram);   // handshake edge
      acc_cnt[is_cpu]++;
      expected = ref_mem.exists(addr) ? ref_mem[addr] : 32'h0;
      if (wr) begin
         for (int b = 0; b < 4; b++) if (be[b]) expected[8*b +: 8] = wd[8*b +: 8];
         ref_mem[addr] = expected;
      end
      n = 0;
      while (!rsp.valid && n < 16) begin
         @(negedge clkram);
         rsp = is_cpu ? cpu_rsp : ppu_rsp;
         rdy = is_cpu ? cpu_ready : ppu_ready;
         if (rdy) begin
            errors++;
            $display("%s: ready high while a response is pending", name);
         end
         n++;
      end
      if (!rsp.valid) begin
         errors++;
         $display("%s: no response within 16 cycles for address %h", name, addr);
      end else if (!wr && rsp.rdata !== expected) begin
         errors++;
         $display("MISMATCH %s expected %h actual %h", name, expected, rsp.rdata);
      end
      @(posedge clkram);
      #1;
   endtask

   // withdraw both requests so a finished access is not taken a second time
   task automatic drop_requests();
      ppu_req.valid = 1'b0;
      cpu_req.valid = 1'b0;
   endtask

   // seeded mix of reads and partial writes, valid dropped only on some gaps
   task automatic random_ops(input bit is_cpu, input int count, input string name);
      logic [31:0] rnd;
      logic [31:0] wd;
      int          idx;
      int          gap;
      for (int k = 0; k < count; k++) begin
         rnd = $random(seed);
         idx = int'(rnd[15:8]) % POOL;
         gap = int'(rnd[17:16]);
         wd  = $random(seed);
         access(is_cpu, rnd[0], pool[idx], wd, rnd[7:4], name);
         if (gap > 1) begin
            if (is_cpu) cpu_req.valid = 1'b0;
            else ppu_req.valid = 1'b0;
            repeat (gap) @(posedge clkram);
            #1;
         end
      end
      if (is_cpu) cpu_req.valid = 1'b0;
      else ppu_req.valid = 1'b0;
   endtask

   // ----------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------
   initial begin
      logic [31:0] rnd;
      int          n;
      int          clk0;
      int          ref0;
      int          exp_ref;
      int          got_ref;
      new_scr = 1'b1;
      ppu_req = '0;
      cpu_req = '0;
      for (int i = 0; i < POOL; i++) begin
         rnd     = $random(seed);
         pool[i] = rnd[18:0];
      end
      repeat (4) @(posedge clkram);
      #1 new_scr = 1'b0;

      // power-up, first ppu permit
      n = 0;
      while (!ppu_ready && n < (INIT_CYCLES + 4) * 16) begin
         @(negedge clkram);
         n++;
      end
      if (!ppu_ready) begin
         errors++;
         $display("ppu ready never rose after power-up");
      end
      if (!pre_all_seen || !mode_seen) begin
         errors++;
         $display("power-up did not issue precharge-all followed by load mode");
      end
      if (mode_val !== MODE_EXP) begin
         errors++;
         $display("MISMATCH powerup_mode expected %h actual %h", MODE_EXP, mode_val);
      end
      if (early_active != 0) begin
         errors++;
         $display("%0d active commands came before the mode load", early_active);
      end
      @(posedge clkram);
      #1;

      // every pool word gets a known value, ports alternating
      for (int i = 0; i < POOL; i++) begin
         rnd = $random(seed);
         access(i[0], 1'b1, pool[i], rnd, 4'hf, "prefill");
         drop_requests();
      end

      // cross-port coherence, one full and one partial write
      access(1'b1, 1'b1, pool[0], 32'hc0de_1234, 4'hf, "coh_cpu_wr");
      drop_requests();
      access(1'b0, 1'b0, pool[0], 32'h0, 4'h0, "coh_ppu_rd");
      drop_requests();
      access(1'b0, 1'b1, pool[1], 32'h5a5a_a5a5, 4'b0110, "coh_ppu_wr");
      drop_requests();
      access(1'b1, 1'b0, pool[1], 32'h0, 4'h0, "coh_cpu_rd");
      drop_requests();

      // random traffic on both ports, refresh counted over the window
      clk0 = cycles;
      ref0 = refresh_cnt;
      fork
         random_ops(1'b0, 150, "rand_ppu");
         random_ops(1'b1, 150, "rand_cpu");
      join
      exp_ref = (cycles - clk0) / 16 / REFRESH_INTERVAL;
      got_ref = refresh_cnt - ref0;
      if (got_ref < exp_ref - 1 || got_ref > exp_ref + 1) begin
         errors++;
         $display("MISMATCH refresh_count expected %0d actual %0d", exp_ref, got_ref);
      end

      repeat (20) @(posedge clkram);   // stray pulses would show up here
      for (int p = 0; p < 2; p++) begin
         if (hs_cnt[p] != acc_cnt[p] || rsp_cnt[p] != hs_cnt[p]) begin
            errors++;
            $display("port %0d: %0d handshakes, %0d accepted, %0d responses",
                     p, hs_cnt[p], acc_cnt[p], rsp_cnt[p]);
         end
      end

      $display("errors %0d, ppu accesses %0d, cpu accesses %0d, refreshes %0d",
               errors, acc_cnt[0], acc_cnt[1], refresh_cnt);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // whole-run limit
   initial begin
      repeat (100000) @(posedge clkram);
      $display("timeout: simulation did not finish");
      $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire
